/* include/busSizer_settings.svh */
/*
 * Bus sizer settings
 * Lane count and line burst sizing shared by the package and the RTL
 */

`ifndef BUSSIZER_SETTINGS_SVH
`define BUSSIZER_SETTINGS_SVH

//////////////////////////////
// Data path
//////////////////////////////

`define BUS_LANES 4         // Byte lanes per data word, lane 0 is most significant

//////////////////////////////
// Line bursts
//////////////////////////////

// A line is four long words on a 32-bit port
`define BURST_BEATS 4

`define BEAT_CNT_W 3        // Holds 0 to BURST_BEATS with one spare bit

`endif

/* rtl/busSizerPkg.sv */
/*
 * Bus sizer types
 * Sizing states, CPU request fields, port acknowledge codes and the data word views
 */

`default_nettype none

`include "busSizer_settings.svh"

package busSizerPkg;

    //////////////////////////////
    // Sequencer states
    //////////////////////////////

    typedef enum logic [3:0] {
        idle  = 4'd0,   // Waiting for a CPU start
        longA = 4'd1,   // Long word or line, first or only port cycle
        longB = 4'd2,   // Second half toward a 16-bit port
        word0 = 4'd3,
        word2 = 4'd4,
        byte0 = 4'd5,
        byte1 = 4'd6,
        byte2 = 4'd7,
        byte3 = 4'd8
    } seqState_t;

    // CPU transfer size, 68040 SIZ encoding
    typedef enum logic [1:0] {
        sizeLong = 2'b00,
        sizeByte = 2'b01,
        sizeWord = 2'b10,
        sizeLine = 2'b11
    } xferSize_t;

    typedef struct packed {
        xferSize_t   size;
        logic [1:0]  addr;      // A1..A0
        logic [1:0]  tt;        // Transfer type, 01 marks a burstable line
        logic        rnw;       // High for reads
    } cpuReq_t;

    // Port size acknowledge from the target
    typedef enum logic [1:0] {
        ack32   = 2'b00,
        ack16   = 2'b01,
        ackNone = 2'b11
    } dsack_t;

    typedef union packed {
        logic [0:`BUS_LANES-1][7:0]      lanes;     // Lane 0 is the MSB
        logic [0:1][`BUS_LANES*4-1:0]    halves;    // Half 0 is the high word
    } busWord_u;

endpackage

`default_nettype wire

/* rtl/sizeSequencer.sv */
/*
 * Dynamic sizing sequencer
 * Decodes the CPU request, issues target starts on nTs and ends the CPU cycle on nTa
 */

`timescale 1ns/10ps
`default_nettype none

module sizeSequencer (
    input  wire                     BCLK,
    input  wire                     nRESET,
    input  wire                     nTsCpu,     // CPU transfer start
    input  busSizerPkg::cpuReq_t    req,
    input  busSizerPkg::dsack_t     dsack,
    input  wire                     nTbi,       // Burst inhibit from the target
    input  wire                     lastBeat,
    output busSizerPkg::seqState_t  state,
    output logic                    nTs,
    output logic                    nTa,
    output logic                    nextBeat,   // One pulse per completed line beat
    output logic                    burstStart
);

    busSizerPkg::seqState_t startState;
    logic halfPending;      // Second 16-bit start issued, longB still to come
    logic burst;            // Current transfer is a burstable line
    logic lastRelease;

    //////////////////////////////
    // Request decode
    //////////////////////////////

    always_comb begin
        case (req.size)
            busSizerPkg::sizeWord:
                startState = req.addr[1] ? busSizerPkg::word2 : busSizerPkg::word0;
            busSizerPkg::sizeByte: begin
                case (req.addr)
                    2'b00:   startState = busSizerPkg::byte0;
                    2'b01:   startState = busSizerPkg::byte1;
                    2'b10:   startState = busSizerPkg::byte2;
                    default: startState = busSizerPkg::byte3;
                endcase
            end
            default: startState = busSizerPkg::longA;   // Long word and line
        endcase
    end

    assign burstStart = (state == busSizerPkg::idle) && !nTsCpu;

    // First ack32 cycle of a line beat, nTa not yet asserted
    assign nextBeat = burst && (state == busSizerPkg::longA)
                      && (dsack == busSizerPkg::ack32) && nTa;

    // Line is done once all beats ran or the target inhibits the burst
    assign lastRelease = !burst || !nTbi || lastBeat;

    //////////////////////////////
    // Sizing FSM
    //////////////////////////////

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            state       <= busSizerPkg::idle;
            nTs         <= 1'b1;
            nTa         <= 1'b1;
            halfPending <= 1'b0;
            burst       <= 1'b0;
        end else begin
            case (state)
                busSizerPkg::idle: begin
                    nTa <= 1'b1;
                    nTs <= nTsCpu;                  // Start follows the CPU by one edge
                    if (!nTsCpu) begin
                        state       <= startState;
                        halfPending <= 1'b0;
                        burst       <= (req.size == busSizerPkg::sizeLine) && (req.tt == 2'b01);
                    end
                end

                busSizerPkg::longA: begin
                    case (dsack)
                        busSizerPkg::ack32: begin
                            nTs <= 1'b1;
                            nTa <= 1'b0;            // Full long word in one port cycle
                        end
                        busSizerPkg::ack16: begin
                            // Only half the word arrived, restart the target once
                            nTs         <= halfPending;
                            halfPending <= 1'b1;
                        end
                        busSizerPkg::ackNone: begin
                            nTs <= 1'b1;
                            if (halfPending) begin
                                state       <= busSizerPkg::longB;
                                halfPending <= 1'b0;
                            end else if (!nTa) begin
                                nTa <= 1'b1;        // End of a beat
                                if (lastRelease)
                                    state <= busSizerPkg::idle;
                            end
                        end
                        default: nTs <= 1'b1;
                    endcase
                end

                // longB, word and byte states end after a single port cycle
                default: begin
                    nTs <= 1'b1;
                    if (dsack != busSizerPkg::ackNone) begin
                        nTa <= 1'b0;
                    end else if (!nTa) begin
                        nTa   <= 1'b1;
                        state <= busSizerPkg::idle;
                    end
                end
            endcase
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Every target start is a single cycle pulse, also for the second 16-bit start
    assert property (@(posedge BCLK) disable iff (!nRESET)
        !nTs |=> nTs)
        else $error("nTs held low for two cycles");

    // A transfer only begins from a sampled CPU start
    assert property (@(posedge BCLK) disable iff (!nRESET)
        (state == busSizerPkg::idle) ##1 (state != busSizerPkg::idle) |-> $past(!nTsCpu))
        else $error("Sequencer left idle without nTsCpu");

endmodule

`default_nettype wire

/* rtl/burstBeatCounter.sv */
/*
 * Line burst beat counter
 * Counts completed beats of a line and flags the last one
 */

`timescale 1ns/10ps
`default_nettype none

`include "busSizer_settings.svh"

module burstBeatCounter (
    input  wire   BCLK,
    input  wire   nRESET,
    input  wire   burstStart,   // Sequencer leaving idle
    input  wire   nextBeat,     // One completed beat
    output logic  lastBeat
);

    localparam logic [`BEAT_CNT_W-1:0] beatLimit = `BURST_BEATS;

    logic [`BEAT_CNT_W-1:0] beatCount;

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET)
            beatCount <= '0;
        else if (burstStart)
            beatCount <= '0;                // New transfer
        else if (nextBeat)
            beatCount <= beatCount + 1'b1;
    end

    assign lastBeat = (beatCount == beatLimit);

    // The sequencer must end the line before a fifth beat is counted
    assert property (@(posedge BCLK) disable iff (!nRESET)
        beatCount <= beatLimit)
        else $error("Burst beat count above the line length");

endmodule

`default_nettype wire

/* rtl/writeLaneSteer.sv */
/*
 * Write lane steering
 * Moves CPU write bytes onto the target lanes the port samples in each sizing state
 */

`timescale 1ns/10ps
`default_nettype none

module writeLaneSteer (
    input  busSizerPkg::seqState_t  state,
    input  busSizerPkg::busWord_u   cpuWrData,
    output busSizerPkg::busWord_u   portWrData
);

    always_comb begin
        portWrData = cpuWrData;     // Long, word 0 and byte 0 pass straight through
        case (state)
            busSizerPkg::idle:
                portWrData = '0;

            // Second 16-bit cycle carries the CPU low word on the port high word
            busSizerPkg::longB:
                portWrData.halves[0] = cpuWrData.halves[1];

            busSizerPkg::word2: begin
                portWrData.lanes[0] = cpuWrData.lanes[2];
                portWrData.lanes[1] = cpuWrData.lanes[3];
            end

            busSizerPkg::byte1:
                portWrData.lanes[0] = cpuWrData.lanes[1];   // Even lane of a 16-bit port

            busSizerPkg::byte2:
                portWrData.lanes[0] = cpuWrData.lanes[2];

            // Byte 3 is seen on every lane, whatever the port width
            busSizerPkg::byte3: begin
                portWrData.lanes[0] = cpuWrData.lanes[3];
                portWrData.lanes[1] = cpuWrData.lanes[3];
                portWrData.lanes[2] = cpuWrData.lanes[3];
            end

            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/readLaneCollect.sv */
/*
 * Read lane collector
 * Registers target read bytes into the CPU lanes on each port acknowledge
 */

`timescale 1ns/10ps
`default_nettype none

module readLaneCollect (
    input  wire                     BCLK,
    input  wire                     nRESET,
    input  busSizerPkg::seqState_t  state,
    input  busSizerPkg::dsack_t     dsack,
    input  busSizerPkg::busWord_u   portRdData,
    input  wire                     busGranted,
    input  wire                     rnw,
    output busSizerPkg::busWord_u   cpuRdData
);

    busSizerPkg::busWord_u rdHold;      // Collected CPU word

    //////////////////////////////
    // Latch on port acknowledge
    //////////////////////////////

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            rdHold <= '0;
        end else if (dsack != busSizerPkg::ackNone) begin
            case (state)
                busSizerPkg::longA: begin
                    if (dsack == busSizerPkg::ack32)
                        rdHold <= portRdData;                       // Whole long word
                    else
                        rdHold.halves[0] <= portRdData.halves[0];   // High word first
                end
                busSizerPkg::longB:
                    rdHold.halves[1] <= portRdData.halves[0];   // 16-bit port answers high

                busSizerPkg::word0: begin
                    rdHold.lanes[0] <= portRdData.lanes[0];
                    rdHold.lanes[1] <= portRdData.lanes[1];
                end
                busSizerPkg::word2: begin
                    rdHold.lanes[2] <= portRdData.lanes[2];
                    rdHold.lanes[3] <= portRdData.lanes[3];
                end

                // Single addressed byte, other lanes hold
                busSizerPkg::byte0: rdHold.lanes[0] <= portRdData.lanes[0];
                busSizerPkg::byte1: rdHold.lanes[1] <= portRdData.lanes[1];
                busSizerPkg::byte2: rdHold.lanes[2] <= portRdData.lanes[2];
                busSizerPkg::byte3: rdHold.lanes[3] <= portRdData.lanes[3];
                default: ;
            endcase
        end
    end

    // CPU side only sees data on granted reads
    assign cpuRdData = (busGranted && rnw) ? rdHold : '0;

    // 16-bit termination is only handled for long words and lines
    assert property (@(posedge BCLK) disable iff (!nRESET)
        (dsack == busSizerPkg::ack16)
            |-> (state == busSizerPkg::longA) || (state == busSizerPkg::longB))
        else $error("16-bit acknowledge outside a long word transfer");

endmodule

`default_nettype wire

/* rtl/busSizerTop.sv */
/*
 * Dynamic bus sizing bridge
 * Connects a 68040-style CPU bus to 32-bit and 16-bit target ports
 */

`timescale 1ns/10ps
`default_nettype none

module busSizerTop (
    input  wire                     BCLK,
    input  wire                     nRESET,
    // CPU side
    input  wire                     nTsCpu,
    input  busSizerPkg::cpuReq_t    req,
    input  wire                     nTbi,
    input  wire                     busGranted,     // Enables the CPU read data
    input  busSizerPkg::busWord_u   cpuWrData,
    output logic                    nTa,
    output busSizerPkg::busWord_u   cpuRdData,
    // Target side
    output logic                    nTs,
    input  busSizerPkg::dsack_t     dsack,
    input  busSizerPkg::busWord_u   portRdData,
    output busSizerPkg::busWord_u   portWrData
);

    busSizerPkg::seqState_t state;
    logic nextBeat;
    logic burstStart;
    logic lastBeat;

    //////////////////////////////
    // Control
    //////////////////////////////

    sizeSequencer uSequencer (
        .BCLK       (BCLK),
        .nRESET     (nRESET),
        .nTsCpu     (nTsCpu),
        .req        (req),
        .dsack      (dsack),
        .nTbi       (nTbi),
        .lastBeat   (lastBeat),
        .state      (state),
        .nTs        (nTs),
        .nTa        (nTa),
        .nextBeat   (nextBeat),
        .burstStart (burstStart)
    );

    burstBeatCounter uBeatCounter (
        .BCLK       (BCLK),
        .nRESET     (nRESET),
        .burstStart (burstStart),
        .nextBeat   (nextBeat),
        .lastBeat   (lastBeat)
    );

    //////////////////////////////
    // Data lanes
    //////////////////////////////

    writeLaneSteer uWriteSteer (
        .state      (state),
        .cpuWrData  (cpuWrData),
        .portWrData (portWrData)
    );

    readLaneCollect uReadCollect (
        .BCLK       (BCLK),
        .nRESET     (nRESET),
        .state      (state),
        .dsack      (dsack),
        .portRdData (portRdData),
        .busGranted (busGranted),
        .rnw        (req.rnw),          // Held by the CPU for the whole transfer
        .cpuRdData  (cpuRdData)
    );

endmodule

`default_nettype wire

/* bench/tbClockGen.sv */
/*
 * Testbench clock and reset
 * BCLK with a 4 ns period, nRESET held low for the first two cycles
 */

`timescale 1ns/10ps
`default_nettype none

module tbClockGen (
    output logic BCLK,
    output logic nRESET
);

    initial begin
        BCLK   = 1'b0;
        nRESET = 1'b0;                  // Reset from time zero
        repeat (2) @(posedge BCLK);
        #1 nRESET = 1'b1;               // Released off the edge
    end

    always #2 BCLK = ~BCLK;             // 4 ns period

endmodule

`default_nettype wire

/* bench/busSizerTb.sv */
/*
 * Bus sizer testbench
 * Replays transfers from the stim file against a 32-bit or 16-bit target model
 * and checks target starts, acknowledges and steered data
 */

`timescale 1ns/10ps
`default_nettype none

`include "busSizer_settings.svh"

module busSizerTb;

    localparam int maxLines  = 32;
    localparam int lineWords = 8;       // Words per stim line
    localparam int jitterMax = 2;       // Extra random wait cycles
    localparam logic [31:0] beatStep = 32'h0101_0101;   // Read data change per beat

    wire BCLK;
    wire nRESET;

    logic                   nTsCpu;
    busSizerPkg::cpuReq_t   req;
    logic                   nTbi;
    logic                   busGranted;
    busSizerPkg::busWord_u  cpuWrData;
    busSizerPkg::busWord_u  cpuRdData;
    logic                   nTa;
    logic                   nTs;
    busSizerPkg::dsack_t    dsack;
    busSizerPkg::busWord_u  portRdData;
    busSizerPkg::busWord_u  portWrData;

    logic [31:0] stim [0:maxLines*lineWords-1];
    int lineCount;
    int errorCount;
    int maxWait;
    int seedValue;
    bit loaded;
    int nTsLows;                        // Low cycles seen in the current test
    int nTaLows;
    busSizerPkg::dsack_t lastDsack;
    logic lastNTa;

    tbClockGen uClock (.BCLK(BCLK), .nRESET(nRESET));

    busSizerTop u_dut (
        .BCLK(BCLK), .nRESET(nRESET), .nTsCpu(nTsCpu), .req(req), .nTbi(nTbi),
        .busGranted(busGranted), .cpuWrData(cpuWrData), .nTa(nTa),
        .cpuRdData(cpuRdData), .nTs(nTs), .dsack(dsack),
        .portRdData(portRdData), .portWrData(portWrData)
    );

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s expected %h got %h", name, expected, actual);
            errorCount++;
        end
    endtask

    // CPU lanes filled by a read of this size and address
    function automatic logic [31:0] laneMask(input logic [1:0] size, input logic [1:0] addr);
        case (size)
            2'b10:   laneMask = addr[1] ? 32'h0000_FFFF : 32'hFFFF_0000;
            2'b01:   laneMask = 32'hFF00_0000 >> (8 * addr);
            default: laneMask = 32'hFFFF_FFFF;      // Long word and line
        endcase
    endfunction

    task automatic waitStart();
        while (nTs) begin
            @(posedge BCLK);
            #1;
        end
    endtask

    // Target model, one acknowledged port cycle after a random wait
    task automatic answerPort(input int waitCycles, input busSizerPkg::dsack_t code,
                              input logic [31:0] data, output logic [31:0] wrSeen);
        int jitter;
        jitter = $urandom % (jitterMax + 1);
        repeat (waitCycles + jitter + 1) @(posedge BCLK);
        #1;
        dsack      = code;
        portRdData = data;
        wrSeen     = portWrData;        // State is stable between edges
        @(posedge BCLK);
        #1;
        dsack = busSizerPkg::ackNone;
    endtask

    task automatic collectBeat(input logic rnw, input logic [31:0] expected,
                               input logic [31:0] mask);
        while (nTa) begin
            @(posedge BCLK);
            #1;
        end
        if (rnw)
            checkValue("cpuRdData", expected & mask, cpuRdData & mask);
        else
            checkValue("cpuRdData", 32'h0, cpuRdData);  // Writes show no read data
        while (!nTa) begin
            @(posedge BCLK);
            #1;
        end
    endtask

    task automatic runTest(input int idx);
        logic [31:0] cmd, port, waitCyc, wrData, rdData, expWr0, expWr1, expRd;
        logic [31:0] wrSeen, mask;
        int beats;
        int errorsBefore;
        cmd     = stim[idx*lineWords];
        port    = stim[idx*lineWords+1];
        waitCyc = stim[idx*lineWords+2];
        wrData  = stim[idx*lineWords+3];
        rdData  = stim[idx*lineWords+4];
        expWr0  = stim[idx*lineWords+5];
        expWr1  = stim[idx*lineWords+6];
        expRd   = stim[idx*lineWords+7];
        errorsBefore = errorCount;
        // Burstable line on a 32-bit port without inhibit runs the full line
        beats = (cmd[7:6] == 2'b11 && cmd[3:2] == 2'b01 && cmd[0] && port == 32'h20)
                ? `BURST_BEATS : 1;
        mask  = laneMask(cmd[7:6], cmd[5:4]);
        req.size  = busSizerPkg::xferSize_t'(cmd[7:6]);
        req.addr  = cmd[5:4];
        req.tt    = cmd[3:2];
        req.rnw   = cmd[1];
        nTbi      = cmd[0];
        cpuWrData = wrData;
        nTsLows   = 0;
        nTaLows   = 0;
        nTsCpu    = 1'b0;
        @(posedge BCLK);
        #1 nTsCpu = 1'b1;
        waitStart();
        if (port == 32'h10) begin
            // 16-bit port, high half then low half on the port high word
            answerPort(waitCyc, busSizerPkg::ack16, rdData, wrSeen);
            if (!cmd[1]) checkValue("portWrData", expWr0, wrSeen);
            waitStart();
            answerPort(waitCyc, busSizerPkg::ack16, {rdData[15:0], 16'h0}, wrSeen);
            if (!cmd[1]) checkValue("portWrData", expWr1, wrSeen);
            collectBeat(cmd[1], expRd, mask);
        end else begin
            for (int beat = 0; beat < beats; beat++) begin
                answerPort(waitCyc, busSizerPkg::ack32, rdData + beat * beatStep, wrSeen);
                if (!cmd[1]) checkValue("portWrData", expWr0, wrSeen);
                collectBeat(cmd[1], expRd + beat * beatStep, mask);
            end
        end
        repeat (2) @(posedge BCLK);
        #1;
        checkValue("nTs pulses", (port == 32'h10) ? 2 : 1, nTsLows);
        checkValue("nTa pulses", beats, nTaLows);
        if (cmd[1]) begin
            // Collected read word is hidden from the CPU bus without a grant
            busGranted = 1'b0;
            @(posedge BCLK);
            #1;
            checkValue("cpuRdData", 32'h0, cpuRdData);
            busGranted = 1'b1;
        end
        $display("test %0d cmd %02h port %0d beats %0d: %s", idx, cmd[7:0],
                 (port == 32'h10) ? 16 : 32, beats,
                 (errorCount == errorsBefore) ? "ok" : "mismatch");
    endtask

    //////////////////////////////
    // Bus monitor
    //////////////////////////////

    always @(negedge BCLK) begin
        if (nRESET) begin
            if (!nTs) nTsLows++;
            if (!nTa) nTaLows++;
            // nTa may only fall after a sampled port acknowledge
            if (!nTa && lastNTa && lastDsack == busSizerPkg::ackNone) begin
                $display("nTa went low without a target acknowledge");
                errorCount++;
            end
        end
        lastNTa   = nTa;
        lastDsack = dsack;
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        seedValue  = $urandom(32'h1930_5231);
        nTsCpu     = 1'b1;
        req        = '0;
        req.rnw    = 1'b1;
        nTbi       = 1'b1;
        busGranted = 1'b1;
        cpuWrData  = '0;
        dsack      = busSizerPkg::ackNone;
        portRdData = '0;
        lastDsack  = busSizerPkg::ackNone;
        lastNTa    = 1'b1;
        errorCount = 0;
        $readmemh("bench/busSizer_stim.txt", stim);
        lineCount = 0;
        maxWait   = 0;
        while (lineCount < maxLines && stim[lineCount*lineWords] !== 'x) begin
            if (stim[lineCount*lineWords+2] > maxWait) maxWait = stim[lineCount*lineWords+2];
            lineCount++;
        end
        maxWait = maxWait + jitterMax;
        loaded  = 1'b1;

        @(posedge nRESET);
        @(posedge BCLK);
        #1;
        checkValue("nTs", 32'h1, nTs);              // Idle bus after reset
        checkValue("nTa", 32'h1, nTa);
        checkValue("cpuRdData", 32'h0, cpuRdData);
        $display("reset check: %s", (errorCount == 0) ? "ok" : "mismatch");

        for (int i = 0; i < lineCount; i++)
            runTest(i);

        $display("%0d tests run, %0d checks failed", lineCount, errorCount);
        if (errorCount == 0 && lineCount > 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    // Watchdog sized from the stim length
    initial begin
        int limitCycles;
        wait (loaded);
        limitCycles = lineCount * `BURST_BEATS * (maxWait + 4) + 20;
        repeat (limitCycles) @(posedge BCLK);
        $display("Run timed out waiting for nTa");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/busSizer_stim.txt */
// cmd {size[1:0] addr[1:0] tt[1:0] rnw nTbi}, port (20 = 32-bit, 10 = 16-bit), wait,
// wrData, rdData, expWr first port cycle, expWr second port cycle, expRd
03 20 1 00000000 11223344 00000000 00000000 11223344
01 20 0 A1B2C3D4 00000000 A1B2C3D4 00000000 00000000
03 10 2 00000000 CAFEBABE 00000000 00000000 CAFEBABE
01 10 0 12345678 00000000 12345678 56785678 00000000
83 20 1 00000000 55667788 00000000 00000000 55660000
A3 20 0 00000000 55667788 00000000 00000000 00007788
81 20 2 0A0B0C0D 00000000 0A0B0C0D 00000000 00000000
A1 20 1 0A0B0C0D 00000000 0C0D0C0D 00000000 00000000
43 20 0 00000000 8899AABB 00000000 00000000 88000000
53 20 1 00000000 8899AABB 00000000 00000000 00990000
63 20 2 00000000 8899AABB 00000000 00000000 0000AA00
73 20 3 00000000 8899AABB 00000000 00000000 000000BB
41 20 0 F1E2D3C4 00000000 F1E2D3C4 00000000 00000000
51 20 1 F1E2D3C4 00000000 E2E2D3C4 00000000 00000000
61 20 2 F1E2D3C4 00000000 D3E2D3C4 00000000 00000000
71 20 0 F1E2D3C4 00000000 C4C4C4C4 00000000 00000000
C7 20 1 00000000 10203040 00000000 00000000 10203040
C5 20 2 0F1E2D3C 00000000 0F1E2D3C 00000000 00000000
C6 20 1 00000000 A0B0C0D0 00000000 00000000 A0B0C0D0

/* busSizer.f */
+incdir+include
rtl/busSizerPkg.sv
rtl/sizeSequencer.sv
rtl/burstBeatCounter.sv
rtl/writeLaneSteer.sv
rtl/readLaneCollect.sv
rtl/busSizerTop.sv
bench/tbClockGen.sv
bench/busSizerTb.sv

/* Bender.yml */
package:
  name: busSizer

export_include_dirs:
  - include

sources:
  - files:
      - rtl/busSizerPkg.sv
      - rtl/sizeSequencer.sv
      - rtl/burstBeatCounter.sv
      - rtl/writeLaneSteer.sv
      - rtl/readLaneCollect.sv
      - rtl/busSizerTop.sv
  - target: test
    files:
      - bench/tbClockGen.sv
      - bench/busSizerTb.sv
